//--- Bender.yml
package:
  name: rv_core

sources:
  - include_dirs:
      - source
    files:
      - source/rv_pkg.sv
      - source/rv_decode.sv
      - source/rv_register_file.sv
      - source/rv_execute.sv
      - source/rv_result.sv
      - source/rv_core.sv
  - target: test
    include_dirs:
      - source
    files:
      - tests/rv_core_properties.sv
      - tests/rv_core_tb.sv

//--- list.f
+incdir+source
source/rv_pkg.sv
source/rv_decode.sv
source/rv_register_file.sv
source/rv_execute.sv
source/rv_result.sv
source/rv_core.sv
tests/rv_core_properties.sv
tests/rv_core_tb.sv

//--- source/rv_consts.svh
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// data path width
`define XLEN 64

// general registers, x0 included
`define REG_COUNT 32

`define RESET_PC 64'h0000_0000_8000_0000

// exit code when decode finds no match
`define ILLEGAL_EXIT 64'hffff_ffff_ffff_ffff

`endif

//--- source/rv_core.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_core import rv_pkg::*; (
  input  logic              clk,
  input  logic              reset,
  output logic [`XLEN-1:0]  pc,
  input  logic [31:0]       instr,
  output logic [`XLEN-1:0]  data_addr,
  output logic [`XLEN-1:0]  data_wdata,
  output logic [7:0]        data_wmask,
  output logic              mem_write,
  input  logic [`XLEN-1:0]  data_rdata,
  output logic              halted,
  output logic [`XLEN-1:0]  exit_code
);

  op_e              op;
  logic [4:0]       rd;
  logic [4:0]       rs1;
  logic [4:0]       rs2;
  logic [`XLEN-1:0] imm;
  logic [`XLEN-1:0] src1;
  logic [`XLEN-1:0] src2;
  logic [`XLEN-1:0] alu_out;
  logic [`XLEN-1:0] next_pc;
  logic [`XLEN-1:0] wb_data;
  logic             wb_enable;

  rv_decode u_decode (
    .instr (instr),
    .op    (op),
    .rd    (rd),
    .rs1   (rs1),
    .rs2   (rs2),
    .imm   (imm)
  );

  rv_register_file u_regs (
    .clk       (clk),
    .reset     (reset),
    .rs1       (rs1),
    .rs2       (rs2),
    .src1      (src1),
    .src2      (src2),
    .rd        (rd),
    .wb_data   (wb_data),
    .wb_enable (wb_enable)
  );

  rv_execute u_execute (
    .op      (op),
    .pc      (pc),
    .src1    (src1),
    .src2    (src2),
    .imm     (imm),
    .alu_out (alu_out),
    .next_pc (next_pc)
  );

  // no stores or writes while in reset
  rv_result u_result (
    .op         (op),
    .alu_out    (alu_out),
    .pc         (pc),
    .imm        (imm),
    .src2       (src2),
    .halted     (halted || reset),
    .data_rdata (data_rdata),
    .data_addr  (data_addr),
    .data_wdata (data_wdata),
    .data_wmask (data_wmask),
    .mem_write  (mem_write),
    .wb_data    (wb_data),
    .wb_enable  (wb_enable)
  );

  always_ff @(posedge clk) begin
    if (reset) begin
      pc        <= `RESET_PC;
      halted    <= 1'b0;
      exit_code <= '0;
    end else if (!halted) begin
      if (op == op_ebreak) begin
        // src1 carries a0 here
        halted    <= 1'b1;
        exit_code <= src1;
      end else if (op == op_illegal) begin
        halted    <= 1'b1;
        exit_code <= `ILLEGAL_EXIT;
      end else begin
        pc <= next_pc;
      end
    end
  end

endmodule

//--- source/rv_decode.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_decode import rv_pkg::*; (
  input  logic [31:0]       instr,
  output op_e               op,
  output logic [4:0]        rd,
  output logic [4:0]        rs1,
  output logic [4:0]        rs2,
  output logic [`XLEN-1:0]  imm
);

  logic [6:0]       opcode;
  logic [2:0]       funct3;
  logic [6:0]       funct7;
  logic [`XLEN-1:0] imm_i;
  logic [`XLEN-1:0] imm_s;
  logic [`XLEN-1:0] imm_b;
  logic [`XLEN-1:0] imm_u;
  logic [`XLEN-1:0] imm_j;
  logic [`XLEN-1:0] imm_sh;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  assign imm_i = {{(`XLEN-12){instr[31]}}, instr[31:20]};
  assign imm_s = {{(`XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{(`XLEN-13){instr[31]}}, instr[31], instr[7], instr[30:25],
                  instr[11:8], 1'b0};
  assign imm_u = {{(`XLEN-32){instr[31]}}, instr[31:12], 12'b0};
  assign imm_j = {{(`XLEN-21){instr[31]}}, instr[31], instr[19:12], instr[20],
                  instr[30:21], 1'b0};
  // rv64 shamt is six bits
  assign imm_sh = {{(`XLEN-6){1'b0}}, instr[25:20]};

  always_comb begin
    op  = op_illegal;
    imm = '0;
    rd  = instr[11:7];
    rs1 = instr[19:15];
    rs2 = instr[24:20];
    case (opcode)
      7'b0110011: begin
        case ({funct7, funct3})
          10'b0000000_000: op = op_add;
          10'b0100000_000: op = op_sub;
          10'b0000000_001: op = op_sll;
          10'b0000000_010: op = op_slt;
          10'b0000000_100: op = op_xor;
          10'b0000000_101: op = op_srl;
          10'b0100000_101: op = op_sra;
          10'b0000000_110: op = op_or;
          10'b0000000_111: op = op_and;
          default: op = op_illegal;
        endcase
      end
      7'b0010011: begin
        imm = imm_i;
        case (funct3)
          3'b000: op = op_addi;
          3'b010: op = op_slti;
          3'b100: op = op_xori;
          3'b110: op = op_ori;
          3'b111: op = op_andi;
          3'b001: begin
            imm = imm_sh;
            if (instr[31:26] == 6'b000000) op = op_slli;
          end
          3'b101: begin
            imm = imm_sh;
            if (instr[31:26] == 6'b000000) op = op_srli;
            else if (instr[31:26] == 6'b010000) op = op_srai;
          end
          default: op = op_illegal;
        endcase
      end
      7'b0111011: if ({funct7, funct3} == 10'b0) op = op_addw;
      7'b0011011: begin
        imm = imm_i;
        if (funct3 == 3'b000) op = op_addiw;
      end
      7'b0110111: begin
        op  = op_lui;
        imm = imm_u;
      end
      7'b0010111: begin
        op  = op_auipc;
        imm = imm_u;
      end
      7'b1101111: begin
        op  = op_jal;
        imm = imm_j;
      end
      7'b1100111: begin
        imm = imm_i;
        if (funct3 == 3'b000) op = op_jalr;
      end
      7'b1100011: begin
        imm = imm_b;
        if (funct3 == 3'b000) op = op_beq;
        else if (funct3 == 3'b001) op = op_bne;
      end
      7'b0000011: begin
        imm = imm_i;
        if (funct3 == 3'b011) op = op_ld;
        else if (funct3 == 3'b010) op = op_lw;
        else if (funct3 == 3'b100) op = op_lbu;
      end
      7'b0100011: begin
        imm = imm_s;
        if (funct3 == 3'b011) op = op_sd;
        else if (funct3 == 3'b010) op = op_sw;
        else if (funct3 == 3'b000) op = op_sb;
      end
      7'b1110011: begin
        // a0 goes out on the rs1 port for the exit code
        if (instr == 32'h0010_0073) begin
          op  = op_ebreak;
          rs1 = 5'd10;
        end
      end
      default: op = op_illegal;
    endcase
  end

endmodule

//--- source/rv_execute.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_execute import rv_pkg::*; (
  input  op_e               op,
  input  logic [`XLEN-1:0]  pc,
  input  logic [`XLEN-1:0]  src1,
  input  logic [`XLEN-1:0]  src2,
  input  logic [`XLEN-1:0]  imm,
  output logic [`XLEN-1:0]  alu_out,
  output logic [`XLEN-1:0]  next_pc
);

  alu_mode_e        mode;
  logic             use_imm;
  logic             taken;
  logic [`XLEN-1:0] opnd_a;
  logic [`XLEN-1:0] opnd_b;
  logic [`XLEN-1:0] alu_res;
  logic [`XLEN-1:0] snpc;
  logic [`XLEN-1:0] branch_target;

  always_comb begin
    mode    = alu_add;
    use_imm = 1'b1;
    case (op)
      op_add, op_addw: use_imm = 1'b0;
      op_sub: begin
        mode    = alu_sub;
        use_imm = 1'b0;
      end
      op_and: begin
        mode    = alu_and;
        use_imm = 1'b0;
      end
      op_or: begin
        mode    = alu_or;
        use_imm = 1'b0;
      end
      op_xor: begin
        mode    = alu_xor;
        use_imm = 1'b0;
      end
      op_sll: begin
        mode    = alu_sll;
        use_imm = 1'b0;
      end
      op_srl: begin
        mode    = alu_srl;
        use_imm = 1'b0;
      end
      op_sra: begin
        mode    = alu_sra;
        use_imm = 1'b0;
      end
      op_slt: begin
        mode    = alu_slt;
        use_imm = 1'b0;
      end
      // equality through the subtractor
      op_beq, op_bne: begin
        mode    = alu_sub;
        use_imm = 1'b0;
      end
      op_andi: mode = alu_and;
      op_ori:  mode = alu_or;
      op_xori: mode = alu_xor;
      op_slti: mode = alu_slt;
      op_slli: mode = alu_sll;
      op_srli: mode = alu_srl;
      op_srai: mode = alu_sra;
      op_lui:  mode = alu_pass_b;
      default: mode = alu_add;
    endcase
  end

  assign opnd_a = (op == op_auipc || op == op_jal) ? pc : src1;
  assign opnd_b = use_imm ? imm : src2;

  always_comb begin
    case (mode)
      alu_sub:    alu_res = opnd_a - opnd_b;
      alu_and:    alu_res = opnd_a & opnd_b;
      alu_or:     alu_res = opnd_a | opnd_b;
      alu_xor:    alu_res = opnd_a ^ opnd_b;
      alu_sll:    alu_res = opnd_a << opnd_b[5:0];
      alu_srl:    alu_res = opnd_a >> opnd_b[5:0];
      alu_sra:    alu_res = $signed(opnd_a) >>> opnd_b[5:0];
      alu_slt:    alu_res = {{(`XLEN-1){1'b0}}, $signed(opnd_a) < $signed(opnd_b)};
      alu_pass_b: alu_res = opnd_b;
      default:    alu_res = opnd_a + opnd_b;
    endcase
  end

  // word ops keep the low half, sign-extended
  assign alu_out = (op == op_addw || op == op_addiw) ?
                   {{(`XLEN-32){alu_res[31]}}, alu_res[31:0]} : alu_res;

  assign snpc          = pc + `XLEN'(4);
  assign branch_target = pc + imm;
  assign taken = (op == op_beq && alu_out == '0) || (op == op_bne && alu_out != '0);

  always_comb begin
    case (op)
      op_jal:  next_pc = alu_out;
      op_jalr: next_pc = {alu_out[`XLEN-1:1], 1'b0};
      default: next_pc = taken ? branch_target : snpc;
    endcase
  end

endmodule

//--- source/rv_pkg.sv
package rv_pkg;

  // one value per supported instruction
  typedef enum logic [5:0] {
    op_add,
    op_sub,
    op_and,
    op_or,
    op_xor,
    op_sll,
    op_srl,
    op_sra,
    op_slt,
    op_addi,
    op_andi,
    op_ori,
    op_xori,
    op_slti,
    op_slli,
    op_srli,
    op_srai,
    op_addw,
    op_addiw,
    op_lui,
    op_auipc,
    op_jal,
    op_jalr,
    op_beq,
    op_bne,
    op_ld,
    op_lw,
    op_lbu,
    op_sd,
    op_sw,
    op_sb,
    op_ebreak,
    op_illegal
  } op_e;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_sll,
    alu_srl,
    alu_sra,
    alu_slt,
    alu_pass_b
  } alu_mode_e;

endpackage

//--- source/rv_register_file.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_register_file (
  input  logic              clk,
  input  logic              reset,
  input  logic [4:0]        rs1,
  input  logic [4:0]        rs2,
  output logic [`XLEN-1:0]  src1,
  output logic [`XLEN-1:0]  src2,
  input  logic [4:0]        rd,
  input  logic [`XLEN-1:0]  wb_data,
  input  logic              wb_enable
);

  logic [`XLEN-1:0] regs [0:`REG_COUNT-1];

  // x0 is cleared on reset and never written, so it reads zero
  assign src1 = regs[rs1];
  assign src2 = regs[rs2];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_enable && rd != 5'd0) begin
      regs[rd] <= wb_data;
    end
  end

endmodule

//--- source/rv_result.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_result import rv_pkg::*; (
  input  op_e               op,
  input  logic [`XLEN-1:0]  alu_out,
  input  logic [`XLEN-1:0]  pc,
  input  logic [`XLEN-1:0]  imm,
  input  logic [`XLEN-1:0]  src2,
  input  logic              halted,
  input  logic [`XLEN-1:0]  data_rdata,
  output logic [`XLEN-1:0]  data_addr,
  output logic [`XLEN-1:0]  data_wdata,
  output logic [7:0]        data_wmask,
  output logic              mem_write,
  output logic [`XLEN-1:0]  wb_data,
  output logic              wb_enable
);

  logic [2:0]       offset;
  logic [7:0]       store_mask;
  logic [31:0]      load_word;
  logic [`XLEN-1:0] load_byte;
  logic [`XLEN-1:0] load_data;
  logic             writes_reg;

  assign data_addr = alu_out;
  assign offset    = alu_out[2:0];

  // place the source lane at its byte offset
  always_comb begin
    case (op)
      op_sb: begin
        data_wdata = {{(`XLEN-8){1'b0}}, src2[7:0]} << {offset, 3'b000};
        store_mask = 8'h01 << offset;
      end
      op_sw: begin
        data_wdata = {{(`XLEN-32){1'b0}}, src2[31:0]} << {offset[2], 5'b00000};
        store_mask = 8'h0f << {offset[2], 2'b00};
      end
      op_sd: begin
        data_wdata = src2;
        store_mask = 8'hff;
      end
      default: begin
        data_wdata = src2;
        store_mask = 8'h00;
      end
    endcase
  end

  assign mem_write  = (store_mask != 8'h00) && !halted;
  assign data_wmask = mem_write ? store_mask : 8'h00;

  // load lanes
  assign load_word = offset[2] ? data_rdata[63:32] : data_rdata[31:0];
  assign load_byte = {{(`XLEN-8){1'b0}}, data_rdata[{offset, 3'b000} +: 8]};

  always_comb begin
    case (op)
      op_lw:   load_data = {{(`XLEN-32){load_word[31]}}, load_word};
      op_lbu:  load_data = load_byte;
      default: load_data = data_rdata;
    endcase
  end

  always_comb begin
    writes_reg = 1'b1;
    case (op)
      op_ld, op_lw, op_lbu: wb_data = load_data;
      op_jal, op_jalr:      wb_data = pc + `XLEN'(4);
      op_lui:               wb_data = imm;
      op_beq, op_bne, op_sd, op_sw, op_sb, op_ebreak, op_illegal: begin
        wb_data    = alu_out;
        writes_reg = 1'b0;
      end
      default:              wb_data = alu_out;
    endcase
  end

  assign wb_enable = writes_reg && !halted;

endmodule

//--- tests/rv_core_properties.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_core_properties (
  input logic             clk,
  input logic             reset,
  input logic [`XLEN-1:0] pc,
  input logic             halted,
  input logic             mem_write,
  input logic [7:0]       data_wmask
);

  int failures = 0;

  // a halted core holds its pc
  pc_frozen: assert property (@(posedge clk) disable iff (reset) halted |=> $stable(pc))
    else begin
      failures++;
      $error("pc moved while halted");
    end

  no_write_when_idle: assert property (@(posedge clk) (reset || halted) |-> !mem_write)
    else begin
      failures++;
      $error("mem_write high during reset or halt");
    end

  mask_matches_write: assert property (@(posedge clk) (data_wmask != 8'h00) == mem_write)
    else begin
      failures++;
      $error("data_wmask disagrees with mem_write");
    end

endmodule

bind rv_core rv_core_properties u_properties (
  .clk        (clk),
  .reset      (reset),
  .pc         (pc),
  .halted     (halted),
  .mem_write  (mem_write),
  .data_wmask (data_wmask)
);

//--- tests/rv_core_tb.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_core_tb;

  localparam int alu_steps = 60;
  localparam int flow_steps = 60;
  localparam int lane_steps = 60;
  localparam int zero_steps = 20;
  localparam int halt_steps = 10;
  // seven runs, each with 10 reset cycles and a few idle ones
  localparam int watchdog_cycles = alu_steps + flow_steps + lane_steps + zero_steps +
                                   3 * halt_steps + 7 * 13 + 100;

  localparam logic [6:0] opc_load = 7'b0000011;
  localparam logic [6:0] opc_imm = 7'b0010011;
  localparam logic [6:0] opc_immw = 7'b0011011;
  localparam logic [6:0] opc_reg = 7'b0110011;
  localparam logic [6:0] opc_regw = 7'b0111011;
  localparam logic [6:0] opc_lui = 7'b0110111;
  localparam logic [6:0] opc_auipc = 7'b0010111;
  localparam logic [6:0] opc_jalr = 7'b1100111;
  localparam logic [31:0] ebreak_word = 32'h0010_0073;

  logic             clk;
  logic             reset;
  logic [`XLEN-1:0] pc;
  logic [31:0]      instr;
  logic [`XLEN-1:0] data_addr;
  logic [`XLEN-1:0] data_wdata;
  logic [7:0]       data_wmask;
  logic             mem_write;
  logic [`XLEN-1:0] data_rdata;
  logic             halted;
  logic [`XLEN-1:0] exit_code;

  logic [31:0] imem [0:255];
  logic [63:0] dmem [0:255];
  logic [63:0] lcg_state;
  int          errors;
  int          prog_len;

  rv_core dut (
    .clk        (clk),
    .reset      (reset),
    .pc         (pc),
    .instr      (instr),
    .data_addr  (data_addr),
    .data_wdata (data_wdata),
    .data_wmask (data_wmask),
    .mem_write  (mem_write),
    .data_rdata (data_rdata),
    .halted     (halted),
    .exit_code  (exit_code)
  );

  // both memories answer in the same cycle
  assign instr = imem[pc[9:2]];
  assign data_rdata = dmem[data_addr[10:3]];

  always @(posedge clk) begin
    if (mem_write) begin
      for (int i = 0; i < 8; i++) begin
        if (data_wmask[i]) dmem[data_addr[10:3]][8*i +: 8] <= data_wdata[8*i +: 8];
      end
    end
  end

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [63:0] next_rand();
    logic [31:0] hi;
    lcg_state = lcg_state * 64'd6364136223846793005 + 64'd1442695040888963407;
    hi = lcg_state[63:32];
    lcg_state = lcg_state * 64'd6364136223846793005 + 64'd1442695040888963407;
    return {hi, lcg_state[63:32]};
  endfunction

  function automatic logic [31:0] rtype(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] itype(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] stype(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] btype(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] jtype(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  function automatic logic [31:0] utype(input logic [19:0] imm, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  task automatic expect_equal(input string name, input logic [63:0] got,
                              input logic [63:0] want);
    if (got !== want) begin
      $display("[FAIL] %s: got %h, expected %h", name, got, want);
      errors++;
    end
  endtask

  task automatic fill_memories();
    for (int i = 0; i < 256; i++) begin
      // opcode zero decodes as illegal
      imem[i] = {i[24:0], 7'b0000000};
      dmem[i] = {32'hd5a0_0000 ^ i, ~i};
    end
    prog_len = 0;
  endtask

  task automatic start_program();
    reset = 1'b1;
    fill_memories();
  endtask

  task automatic emit(input logic [31:0] word);
    imem[prog_len] = word;
    prog_len++;
  endtask

  task automatic run_program(input int budget);
    int cycles;
    repeat (10) @(negedge clk);
    reset = 1'b0;
    cycles = 0;
    while (!halted && cycles < budget) begin
      @(negedge clk);
      cycles++;
    end
    if (!halted) begin
      $display("core did not halt within %0d cycles", budget);
      errors++;
    end
  endtask

  task automatic check_alu_ops();
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] simm;
    logic [63:0] sum;
    logic [63:0] expected [0:18];
    logic [11:0] imm;
    logic [11:0] ifield;
    logic [5:0]  sh;
    logic [2:0]  r_f3 [0:9];
    logic [2:0]  i_f3 [0:8];
    r_f3 = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7, 3'd0};
    i_f3 = '{3'd0, 3'd2, 3'd4, 3'd6, 3'd7, 3'd0, 3'd1, 3'd5, 3'd5};
    a = next_rand();
    b = next_rand();
    imm = 12'(next_rand());
    sh = 6'(next_rand());
    simm = {{52{imm[11]}}, imm};
    start_program();
    dmem[0] = a;
    dmem[1] = b;
    emit(itype(12'd0, 5'd0, 3'b011, 5'd1, opc_load));
    emit(itype(12'd8, 5'd0, 3'b011, 5'd2, opc_load));
    // add sub sll slt xor srl sra or and addw
    for (int k = 0; k < 10; k++) begin
      emit(rtype((k == 1 || k == 6) ? 7'h20 : 7'h00, 5'd2, 5'd1, r_f3[k], 5'd3,
                 (k == 9) ? opc_regw : opc_reg));
      emit(stype(12'(16 + 8 * k), 5'd3, 5'd0, 3'b011));
    end
    // addi slti xori ori andi addiw slli srli srai
    for (int k = 0; k < 9; k++) begin
      ifield = (k < 6) ? imm : {(k == 8) ? 6'b010000 : 6'b000000, sh};
      emit(itype(ifield, 5'd1, i_f3[k], 5'd3, (k == 5) ? opc_immw : opc_imm));
      emit(stype(12'(96 + 8 * k), 5'd3, 5'd0, 3'b011));
    end
    emit(ebreak_word);
    run_program(alu_steps);
    sum = a + b;
    expected[0] = a + b;
    expected[1] = a - b;
    expected[2] = a << b[5:0];
    expected[3] = {63'd0, $signed(a) < $signed(b)};
    expected[4] = a ^ b;
    expected[5] = a >> b[5:0];
    expected[6] = $signed(a) >>> b[5:0];
    expected[7] = a | b;
    expected[8] = a & b;
    expected[9] = {{32{sum[31]}}, sum[31:0]};
    expected[10] = a + simm;
    expected[11] = {63'd0, $signed(a) < $signed(simm)};
    expected[12] = a ^ simm;
    expected[13] = a | simm;
    expected[14] = a & simm;
    sum = a + simm;
    expected[15] = {{32{sum[31]}}, sum[31:0]};
    expected[16] = a << sh;
    expected[17] = a >> sh;
    expected[18] = $signed(a) >>> sh;
    for (int k = 0; k < 19; k++) begin
      expect_equal($sformatf("dmem alu result %0d", k), dmem[2 + k], expected[k]);
    end
  endtask

  task automatic check_control_flow();
    int n;
    n = 3 + int'(next_rand() % 6);
    start_program();
    emit(itype(12'(n), 5'd0, 3'b000, 5'd1, opc_imm));
    emit(itype(12'd0, 5'd0, 3'b000, 5'd2, opc_imm));
    emit(itype(12'd1, 5'd2, 3'b000, 5'd2, opc_imm));
    emit(itype(12'hfff, 5'd1, 3'b000, 5'd1, opc_imm));
    // back to the loop head
    emit(btype(13'h1ff8, 5'd0, 5'd1, 3'b001));
    emit(stype(12'd0, 5'd2, 5'd0, 3'b011));
    emit(jtype(21'd8, 5'd5));
    emit(stype(12'd0, 5'd0, 5'd0, 3'b011));
    emit(stype(12'd8, 5'd5, 5'd0, 3'b011));
    emit(itype(12'd16, 5'd5, 3'b000, 5'd7, opc_jalr));
    emit(stype(12'd0, 5'd0, 5'd0, 3'b011));
    emit(stype(12'd16, 5'd7, 5'd0, 3'b011));
    emit(ebreak_word);
    run_program(flow_steps);
    expect_equal("dmem loop count", dmem[0], 64'(n));
    expect_equal("dmem jal link", dmem[1], `RESET_PC + 64'd28);
    expect_equal("dmem jalr link", dmem[2], `RESET_PC + 64'd40);
    expect_equal("pc", pc, `RESET_PC + 64'd48);
  endtask

  task automatic check_byte_lanes();
    logic [63:0] a;
    logic [63:0] b;
    a = next_rand();
    // one negative and one positive word
    b = (next_rand() | 64'h8000_0000_0000_0000) & ~64'h0000_0000_8000_0000;
    start_program();
    dmem[0] = a;
    dmem[1] = b;
    emit(itype(12'd0, 5'd0, 3'b011, 5'd1, opc_load));
    emit(itype(12'd8, 5'd0, 3'b011, 5'd2, opc_load));
    for (int o = 0; o < 8; o++) begin
      emit(stype(12'(64 + o), 5'd1, 5'd0, 3'b000));
      emit(itype(12'd8, 5'd1, 3'b101, 5'd1, opc_imm));
    end
    emit(stype(12'd72, 5'd2, 5'd0, 3'b010));
    emit(itype(12'd32, 5'd2, 3'b101, 5'd2, opc_imm));
    emit(stype(12'd76, 5'd2, 5'd0, 3'b010));
    for (int o = 0; o < 8; o++) begin
      emit(itype(12'(64 + o), 5'd0, 3'b100, 5'd3, opc_load));
      emit(stype(12'(128 + 8 * o), 5'd3, 5'd0, 3'b011));
    end
    emit(itype(12'd72, 5'd0, 3'b010, 5'd4, opc_load));
    emit(stype(12'd192, 5'd4, 5'd0, 3'b011));
    emit(itype(12'd76, 5'd0, 3'b010, 5'd4, opc_load));
    emit(stype(12'd200, 5'd4, 5'd0, 3'b011));
    emit(ebreak_word);
    run_program(lane_steps);
    expect_equal("dmem sb word", dmem[8], a);
    expect_equal("dmem sw word", dmem[9], b);
    for (int o = 0; o < 8; o++) begin
      expect_equal($sformatf("dmem lbu offset %0d", o), dmem[16 + o], {56'd0, a[8*o +: 8]});
    end
    expect_equal("dmem lw low", dmem[24], {{32{b[31]}}, b[31:0]});
    expect_equal("dmem lw high", dmem[25], {{32{b[63]}}, b[63:32]});
  endtask

  task automatic check_zero_register();
    logic [19:0] u_lui;
    logic [19:0] u_auipc;
    u_lui = 20'(next_rand());
    u_auipc = 20'(next_rand());
    start_program();
    dmem[0] = next_rand() | 64'd1;
    emit(itype(12'd0, 5'd0, 3'b011, 5'd1, opc_load));
    emit(itype(12'd5, 5'd1, 3'b000, 5'd0, opc_imm));
    emit(rtype(7'h00, 5'd1, 5'd1, 3'b000, 5'd0, opc_reg));
    emit(itype(12'd0, 5'd0, 3'b011, 5'd0, opc_load));
    emit(stype(12'd8, 5'd0, 5'd0, 3'b011));
    emit(utype(u_lui, 5'd3, opc_lui));
    emit(stype(12'd16, 5'd3, 5'd0, 3'b011));
    emit(utype(u_auipc, 5'd4, opc_auipc));
    emit(stype(12'd24, 5'd4, 5'd0, 3'b011));
    emit(ebreak_word);
    run_program(zero_steps);
    expect_equal("dmem x0 store", dmem[1], 64'd0);
    expect_equal("dmem lui", dmem[2], {{32{u_lui[19]}}, u_lui, 12'd0});
    expect_equal("dmem auipc", dmem[3],
                 `RESET_PC + 64'd28 + {{32{u_auipc[19]}}, u_auipc, 12'd0});
  endtask

  task automatic check_halt(input logic [11:0] a0_value);
    start_program();
    emit(itype(a0_value, 5'd0, 3'b000, 5'd10, opc_imm));
    emit(ebreak_word);
    run_program(halt_steps);
    expect_equal("halted", {63'd0, halted}, 64'd1);
    expect_equal("exit_code", exit_code, {{52{a0_value[11]}}, a0_value});
    repeat (3) @(negedge clk);
    expect_equal("pc", pc, `RESET_PC + 64'd4);
  endtask

  task automatic check_illegal();
    start_program();
    emit(itype(12'd7, 5'd0, 3'b000, 5'd10, opc_imm));
    emit(32'hffff_ffff);
    run_program(halt_steps);
    expect_equal("halted", {63'd0, halted}, 64'd1);
    expect_equal("exit_code", exit_code, `ILLEGAL_EXIT);
    expect_equal("pc", pc, `RESET_PC + 64'd4);
  endtask

  initial begin
    errors = 0;
    lcg_state = 64'd87607;
    reset = 1'b1;
    fill_memories();
    @(negedge clk);
    check_alu_ops();
    check_control_flow();
    check_byte_lanes();
    check_zero_register();
    check_halt(12'd0);
    check_halt(12'(next_rand()) | 12'h001);
    check_illegal();
    $display("errors: %0d, assertion failures: %0d", errors, dut.u_properties.failures);
    if (errors == 0 && dut.u_properties.failures == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  initial begin
    #(watchdog_cycles * 40);
    $display("watchdog expired after %0d cycles, run stopped", watchdog_cycles);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule
